//--- fetch_macros.svh
// Fetch stage constants shared by the package, RTL and testbench through `include
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Width of PC, target addresses and instruction words
`define FETCH_DATA_WIDTH 32

// First instruction fetched after reset
`define FETCH_RESET_PC 32'h8000_0000

// Sequential increment
`define FETCH_PC_STEP 32'd4

// Trap handler entry
`define FETCH_TRAP_VEC 32'h8000_0080

// EBREAK instruction encoding, stops fetching
`define FETCH_EBREAK 32'h0010_0073

// Instruction SRAM depth in words, index from address bits 7:2
`define FETCH_MEM_WORDS 64

`endif

//--- fetch_pkg.sv
// Types for the fetch stage, imported by the RTL modules and the testbench
`include "fetch_macros.svh"

package fetch_pkg;

  // Next-PC source chosen by the later stages
  typedef enum logic [2:0] {
    SEL_PLUS4  = 3'd0,
    SEL_JALR   = 3'd1,
    SEL_BRANCH = 3'd2,
    SEL_JAL    = 3'd3,
    SEL_TRAP   = 3'd4
  } pc_sel_e;

  // Fetch controller states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_REQ  = 2'd1,
    ST_WAIT = 2'd2,
    ST_DONE = 2'd3
  } fetch_state_e;

  // Redirect info from decode/execute
  typedef struct packed {
    pc_sel_e                       sel;
    logic [`FETCH_DATA_WIDTH-1:0] jump_reg_target;
    logic [`FETCH_DATA_WIDTH-1:0] br_target;
    logic [`FETCH_DATA_WIDTH-1:0] jmp_target;
  } redirect_t;

  // Word handed to the decode stage
  typedef struct packed {
    logic [`FETCH_DATA_WIDTH-1:0] pc;
    logic [`FETCH_DATA_WIDTH-1:0] inst;
  } fetch_out_t;

  // AXI4-Lite read address channel
  typedef struct packed {
    logic                          arvalid;
    logic [`FETCH_DATA_WIDTH-1:0] araddr;
  } axi_ar_t;

  // AXI4-Lite read data channel, rready is always high
  typedef struct packed {
    logic                          rvalid;
    logic [`FETCH_DATA_WIDTH-1:0] rdata;
  } axi_r_t;

endpackage

//--- pc_unit.sv
// Program counter register with the five-way next-PC select, loaded on pc_wen
`timescale 1ns/100ps
`include "fetch_macros.svh"

module pc_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  fetch_pkg::redirect_t          redirect,
  input  logic                          pc_wen,
  output logic [`FETCH_DATA_WIDTH-1:0] pc
);

  import fetch_pkg::*;

  logic [`FETCH_DATA_WIDTH-1:0] pc_q;
  logic [`FETCH_DATA_WIDTH-1:0] pc_plus4;
  logic [`FETCH_DATA_WIDTH-1:0] pc_next;

  assign pc_plus4 = pc_q + `FETCH_PC_STEP;

  // Next PC from the redirect select
  always_comb begin
    case (redirect.sel)
      SEL_PLUS4: begin
        pc_next = pc_plus4;
      end
      SEL_JALR: begin
        pc_next = redirect.jump_reg_target;
      end
      SEL_BRANCH: begin
        pc_next = redirect.br_target;
      end
      SEL_JAL: begin
        pc_next = redirect.jmp_target;
      end
      SEL_TRAP: begin
        pc_next = `FETCH_TRAP_VEC;
      end
      default: begin
        // Unused encodings fall through to sequential
        pc_next = pc_plus4;
      end
    endcase
  end

  // PC only moves on the write-back strobe
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (pc_wen) begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

endmodule

//--- fetch_ctrl.sv
// Fetch FSM that reads one word over AXI4-Lite and offers it to decode with valid/ready
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [`FETCH_DATA_WIDTH-1:0] pc,
  input  logic                          pc_wen,
  input  logic                          idu_ready,
  output fetch_pkg::axi_ar_t            ar,
  input  logic                          arready,
  input  fetch_pkg::axi_r_t             r,
  output fetch_pkg::fetch_out_t         fetch_out,
  output logic                          inst_valid,
  output logic                          halted
);

  import fetch_pkg::*;

  fetch_state_e                  state_q;
  logic                          arvalid_q;
  logic                          halted_q;
  logic                          xfer;
  logic [`FETCH_DATA_WIDTH-1:0] pc_q;
  logic [`FETCH_DATA_WIDTH-1:0] inst_q;

  // Decode takes the word this cycle
  assign xfer = (state_q == ST_DONE) && idu_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= ST_REQ;
      arvalid_q <= 1'b0;
      halted_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          arvalid_q <= 1'b0;
          // Once halted, stay here until reset
          if (pc_wen && !halted_q) begin
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (arvalid_q && arready) begin
            arvalid_q <= 1'b0;
            state_q   <= ST_WAIT;
          end else begin
            arvalid_q <= 1'b1;
          end
        end
        ST_WAIT: begin
          arvalid_q <= 1'b0;
          if (r.rvalid) begin
            state_q <= ST_DONE;
          end
        end
        ST_DONE: begin
          arvalid_q <= 1'b0;
          if (xfer) begin
            state_q <= ST_IDLE;
            if (inst_q == `FETCH_EBREAK) begin
              halted_q <= 1'b1;
            end
          end
        end
        default: begin
          state_q   <= ST_IDLE;
          arvalid_q <= 1'b0;
        end
      endcase
    end
  end

  // Capture returned word with the PC it was fetched from
  always_ff @(posedge clk) begin
    if ((state_q == ST_WAIT) && r.rvalid) begin
      pc_q   <= pc;
      inst_q <= r.rdata;
    end
  end

  assign ar.arvalid = arvalid_q;
  assign ar.araddr  = pc;

  assign fetch_out.pc   = pc_q;
  assign fetch_out.inst = inst_q;

  // Held until decode accepts
  assign inst_valid = (state_q == ST_DONE);
  assign halted     = halted_q;

endmodule

//--- mem_latency_timer.sv
// Loadable down-counter giving the SRAM its per-access read latency
`timescale 1ns/100ps

module mem_latency_timer (
  input  logic       clk,
  input  logic       rst,
  input  logic       load,
  input  logic [2:0] count,
  output logic       done
);

  logic [2:0] cnt_q;

  // Counts down to zero and rests there
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q <= 3'd0;
    end else if (load) begin
      cnt_q <= count;
    end else if (cnt_q != 3'd0) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  // One cycle pulse on the last count
  assign done = (cnt_q == 3'd1);

endmodule

//--- imem_sram.sv
// Read-only instruction SRAM on AXI4-Lite AR/R, contents from imem.hex, latency by address
`timescale 1ns/100ps
`include "fetch_macros.svh"

module imem_sram (
  input  logic               clk,
  input  logic               rst,
  input  fetch_pkg::axi_ar_t ar,
  output logic               arready,
  output fetch_pkg::axi_r_t  r
);

  localparam int IDX_W = $clog2(`FETCH_MEM_WORDS);

  logic [`FETCH_DATA_WIDTH-1:0] mem [`FETCH_MEM_WORDS];
  logic [IDX_W-1:0]              idx_q;
  logic                          busy_q;
  logic                          accept;
  logic [2:0]                    lat_count;
  logic                          lat_done;
  logic                          rvalid_q;
  logic [`FETCH_DATA_WIDTH-1:0] rdata_q;

  initial begin
    $readmemh("imem.hex", mem);
  end

  assign arready = ~busy_q;
  assign accept  = ar.arvalid && arready;

  // Word index bits 1:0 plus one, so 1 to 4 cycles
  assign lat_count = {1'b0, ar.araddr[3:2]} + 3'd1;

  mem_latency_timer u_timer (
    .clk   (clk),
    .rst   (rst),
    .load  (accept),
    .count (lat_count),
    .done  (lat_done)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= lat_done;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (lat_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Upper address bits ignored, addresses wrap over the array
  always_ff @(posedge clk) begin
    if (accept) begin
      idx_q <= ar.araddr[IDX_W+1:2];
    end
    if (lat_done) begin
      rdata_q <= mem[idx_q];
    end
  end

  assign r.rvalid = rvalid_q;
  assign r.rdata  = rdata_q;

endmodule

//--- fetch_top.sv
// Fetch stage top joining PC unit, fetch FSM and instruction SRAM, the DUT of the testbench
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  pc_wen,
  input  logic                  idu_ready,
  output fetch_pkg::fetch_out_t fetch_out,
  output logic                  inst_valid,
  output logic                  halted
);

  import fetch_pkg::*;

  logic [`FETCH_DATA_WIDTH-1:0] pc;
  axi_ar_t                       ar;
  logic                          arready;
  axi_r_t                        r;

  pc_unit u_pc (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .pc_wen   (pc_wen),
    .pc       (pc)
  );

  fetch_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .pc_wen     (pc_wen),
    .idu_ready  (idu_ready),
    .ar         (ar),
    .arready    (arready),
    .r          (r),
    .fetch_out  (fetch_out),
    .inst_valid (inst_valid),
    .halted     (halted)
  );

  imem_sram u_imem (
    .clk     (clk),
    .rst     (rst),
    .ar      (ar),
    .arready (arready),
    .r       (r)
  );

endmodule

//--- tb_fetch.sv
// Self-checking testbench for fetch_top that plays decode and write-back and checks every transfer
`timescale 1ns/100ps
`include "fetch_macros.svh"

module tb_fetch;

  import fetch_pkg::*;

  localparam int TIMEOUT = 50;

  logic       clk;
  logic       rst;
  redirect_t  redirect;
  logic       pc_wen;
  logic       idu_ready;
  fetch_out_t fetch_out;
  logic       inst_valid;
  logic       halted;

  logic [`FETCH_DATA_WIDTH-1:0] model_mem [`FETCH_MEM_WORDS];
  logic [`FETCH_DATA_WIDTH-1:0] model_pc;
  fetch_out_t                    expect_q[$];
  integer                        seed;
  int                            fetches;
  int                            transfers;

  fetch_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .pc_wen     (pc_wen),
    .idu_ready  (idu_ready),
    .fetch_out  (fetch_out),
    .inst_valid (inst_valid),
    .halted     (halted)
  );

  always #10 clk = ~clk;

  // Next PC as the write-back stage expects it
  function automatic logic [31:0] next_pc(input logic [31:0] pc, input redirect_t rd);
    case (rd.sel)
      SEL_JALR:   return rd.jump_reg_target;
      SEL_BRANCH: return rd.br_target;
      SEL_JAL:    return rd.jmp_target;
      SEL_TRAP:   return `FETCH_TRAP_VEC;
      default:    return pc + `FETCH_PC_STEP;
    endcase
  endfunction

  // Upper address bits ignored so the 64-word window wraps
  function automatic logic [31:0] mem_word(input logic [31:0] pc);
    return model_mem[pc[7:2]];
  endfunction

  // Word-aligned target with a random page in bits 9:8 to exercise the wrap
  function automatic logic [31:0] pick_target(input int rnd);
    logic [5:0] idx;
    logic [1:0] page;
    idx  = rnd[5:0];
    page = rnd[9:8];
    if (idx == 6'd40) begin
      idx = 6'd41;
    end
    return `FETCH_RESET_PC + {22'd0, page, idx, 2'b00};
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("** Error at time %0t: %s got %h, expected %h, FSM in %s",
                                $time, what, got, exp, u_dut.u_ctrl.state_q.name()));
    end
  endtask

  // Random select steered off the EBREAK word until the final phase
  task automatic make_redirect(output redirect_t rd);
    logic [2:0]  sel_idx;
    logic [31:0] cand;
    sel_idx            = 3'($unsigned($random(seed)) % 5);
    rd.sel             = pc_sel_e'(sel_idx);
    rd.jump_reg_target = pick_target($random(seed));
    rd.br_target       = pick_target($random(seed));
    rd.jmp_target      = pick_target($random(seed));
    cand               = next_pc(model_pc, rd);
    if (cand[7:2] == 6'd40) begin
      rd.sel = SEL_TRAP;
    end
  endtask

  task automatic wait_inst_valid(input string ctx);
    int n;
    n = 0;
    @(negedge clk);
    while (!inst_valid) begin
      n++;
      if (n >= TIMEOUT) begin
        stop_with_error($sformatf("Timeout: inst_valid did not rise within %0d cycles (%s)",
                                  TIMEOUT, ctx));
      end
      @(negedge clk);
    end
  endtask

  // Stall decode for a while and then take the word
  task automatic take_word(input int stall);
    fetch_out_t held;
    int         n;
    held = fetch_out;
    for (n = 0; n < stall; n++) begin
      @(negedge clk);
      check_value("inst_valid under stall", {31'd0, inst_valid}, 32'd1);
      check_value("held fetch_out.pc", fetch_out.pc, held.pc);
      check_value("held fetch_out.inst", fetch_out.inst, held.inst);
    end
    @(posedge clk);
    #2 idu_ready = 1'b1;
    n = 0;
    @(negedge clk);
    while (!inst_valid) begin
      n++;
      if (n >= TIMEOUT) begin
        stop_with_error("Timeout: no transfer while idu_ready was high");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2 idu_ready = 1'b0;
  endtask

  // One write-back strobe while the stage sits idle
  task automatic pulse_pc_wen(input redirect_t rd);
    redirect = rd;
    pc_wen   = 1'b1;
    @(negedge clk);
    check_value("inst_valid after transfer", {31'd0, inst_valid}, 32'd0);
    @(posedge clk);
    #2 pc_wen = 1'b0;
  endtask

  task automatic issue_fetch(input redirect_t rd);
    fetch_out_t exp_out;
    model_pc     = next_pc(model_pc, rd);
    exp_out.pc   = model_pc;
    exp_out.inst = mem_word(model_pc);
    expect_q.push_back(exp_out);
    fetches++;
    pulse_pc_wen(rd);
  endtask

  task automatic expect_no_fetch();
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (inst_valid) begin
        stop_with_error("inst_valid rose although the core halted on EBREAK");
      end
    end
  endtask

  // Compare process checks each transfer against the model
  always @(negedge clk) begin
    fetch_out_t exp_out;
    if (!rst && inst_valid && idu_ready) begin
      if (expect_q.size() == 0) begin
        stop_with_error("Transfer seen with no fetch outstanding");
      end else begin
        exp_out = expect_q.pop_front();
        check_value("fetch_out.pc", fetch_out.pc, exp_out.pc);
        check_value("fetch_out.inst", fetch_out.inst, exp_out.inst);
        // Halt only takes effect at the edge that ends the transfer
        check_value("halted during transfer", {31'd0, halted}, 32'd0);
        transfers++;
      end
    end
  end

  initial begin
    redirect_t  rd;
    fetch_out_t first;
    int         i;
    seed        = 32'ha2c5_ff99;
    clk         = 1'b1;
    rst         = 1'b1;
    redirect    = '0;
    pc_wen      = 1'b0;
    idu_ready   = 1'b0;
    fetches     = 0;
    transfers   = 0;
    $readmemh("imem.hex", model_mem);

    // First fetch after reset comes from the reset PC
    model_pc   = `FETCH_RESET_PC;
    first.pc   = `FETCH_RESET_PC;
    first.inst = mem_word(`FETCH_RESET_PC);
    expect_q.push_back(first);
    fetches++;

    repeat (5) begin
      @(negedge clk);
      check_value("inst_valid in reset", {31'd0, inst_valid}, 32'd0);
      check_value("halted in reset", {31'd0, halted}, 32'd0);
    end
    @(posedge clk);
    #2 rst = 1'b0;

    wait_inst_valid("first fetch after reset");
    take_word(0);

    // Sequential run across all four latency classes
    rd     = '0;
    rd.sel = SEL_PLUS4;
    for (i = 0; i < 8; i++) begin
      issue_fetch(rd);
      wait_inst_valid("sequential fetch");
      take_word($unsigned($random(seed)) % 6);
    end

    // Random redirects with back-pressure
    for (i = 0; i < 40; i++) begin
      make_redirect(rd);
      issue_fetch(rd);
      wait_inst_valid("redirected fetch");
      take_word($unsigned($random(seed)) % 6);
    end

    // Jump onto the EBREAK word
    rd            = '0;
    rd.sel        = SEL_JAL;
    rd.jmp_target = `FETCH_RESET_PC + 32'd160;
    check_value("model word 40", mem_word(rd.jmp_target), `FETCH_EBREAK);
    issue_fetch(rd);
    wait_inst_valid("EBREAK fetch");
    take_word($unsigned($random(seed)) % 6);
    check_value("halted after EBREAK", {31'd0, halted}, 32'd1);

    // Strobes after the halt start nothing
    rd.sel = SEL_PLUS4;
    for (i = 0; i < 3; i++) begin
      pulse_pc_wen(rd);
      expect_no_fetch();
      @(posedge clk);
      #2;
    end
    check_value("halted at end", {31'd0, halted}, 32'd1);
    check_value("transfer count", transfers, fetches);
    check_value("fetches left unanswered", expect_q.size(), 32'd0);

    $display("Done: no errors");
    $finish;
  end

endmodule

//--- imem.hex
// One 32-bit instruction word per line, word 0 at 0x8000_0000
// addi x1,x1,n filler where n is the word index, EBREAK at word 40
00008093
00108093
00208093
00308093
00408093
00508093
00608093
00708093
00808093
00908093
00a08093
00b08093
00c08093
00d08093
00e08093
00f08093
01008093
01108093
01208093
01308093
01408093
01508093
01608093
01708093
01808093
01908093
01a08093
01b08093
01c08093
01d08093
01e08093
01f08093
02008093
02108093
02208093
02308093
02408093
02508093
02608093
02708093
00100073
02908093
02a08093
02b08093
02c08093
02d08093
02e08093
02f08093
03008093
03108093
03208093
03308093
03408093
03508093
03608093
03708093
03808093
03908093
03a08093
03b08093
03c08093
03d08093
03e08093
03f08093

//--- filelist.f
+incdir+.
fetch_pkg.sv
pc_unit.sv
fetch_ctrl.sv
mem_latency_timer.sv
imem_sram.sv
fetch_top.sv
tb_fetch.sv

//--- Makefile
# Verilator flow for the fetch stage testbench
TOP = tb_fetch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

# Pass only when the run prints the pass line
sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
